// File: verilog/firPkg.sv
package firPkg;

    // ----------------------------------------
    // Filter dimensions
    // ----------------------------------------
    localparam int NumCoeffs = 8;   // Unique taps of the 15-tap symmetric filter
    localparam int NumChans  = 2;   // I and Q

    // ----------------------------------------
    // Data types
    // ----------------------------------------
    typedef logic signed [17:0] sample_t;
    typedef logic signed [15:0] coeff_t;    // Q1.15
    typedef logic signed [37:0] acc_t;      // 19b pre-add x 16b coeff, plus 3 bits growth

    // c0 weights taps 0 and 14, c7 the centre tap
    typedef struct packed {
        coeff_t c0;
        coeff_t c1;
        coeff_t c2;
        coeff_t c3;
        coeff_t c4;
        coeff_t c5;
        coeff_t c6;
        coeff_t c7;
    } coeffSet_t;

    typedef struct packed {
        sample_t i;
        sample_t q;
    } iqSample_t;

    typedef struct packed {
        acc_t i;
        acc_t q;
    } iqAcc_t;

    typedef struct packed {
        logic i;
        logic q;
    } iqFlag_t;

    // Word offsets inside the register window
    typedef enum logic [2:0] {
        RegC0C1   = 3'd0,   // Even coeff in the low half, odd in the high half
        RegC2C3   = 3'd1,
        RegC4C5   = 3'd2,
        RegC6C7   = 3'd3,
        RegStatus = 3'd4    // Bit 0 satI, bit 1 satQ
    } regOff_e;

endpackage

// File: verilog/firCoeffRegs.sv
`timescale 1ns/1ps

module firCoeffRegs import firPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        cs,
    input  logic [2:0]  addr,      // Word offset inside the window
    input  logic [31:0] din,
    input  logic        wr0,
    input  logic        wr1,
    input  logic        wr2,
    input  logic        wr3,
    output logic [31:0] dout,
    input  iqFlag_t     sat,
    output coeffSet_t   coeffs
);

    logic [3:0][31:0] coefWords;   // Indexed by RegC0C1 .. RegC6C7
    logic [1:0]       status;      // Sticky saturation bits
    logic [3:0]       wrB;
    logic             coefHit;
    logic [1:0]       clrBits;

    assign wrB     = {wr3, wr2, wr1, wr0};
    assign coefHit = cs && (addr <= RegC6C7);

    // Write one to clear, byte 0 only
    assign clrBits = (cs && wr0 && (addr == RegStatus)) ? din[1:0] : 2'b00;

    // ----------------------------------------
    // Register writes
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            coefWords <= '0;
            status    <= '0;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (coefHit && wrB[b]) begin
                    coefWords[addr[1:0]][b*8 +: 8] <= din[b*8 +: 8];
                end
            end
            // A new event beats a clear at the same edge
            status <= (status & ~clrBits) | {sat.q, sat.i};
        end
    end

    // ----------------------------------------
    // Read-back, zero latency
    // ----------------------------------------
    always_comb begin
        dout = '0;
        if (cs) begin
            case (regOff_e'(addr))
                RegC0C1, RegC2C3, RegC4C5, RegC6C7: dout = coefWords[addr[1:0]];
                RegStatus:                          dout = {30'd0, status};
                default:                            dout = '0;   // Offsets 5 to 7
            endcase
        end
    end

    // Unpack the coefficient words
    assign coeffs.c0 = coefWords[0][15:0];
    assign coeffs.c1 = coefWords[0][31:16];
    assign coeffs.c2 = coefWords[1][15:0];
    assign coeffs.c3 = coefWords[1][31:16];
    assign coeffs.c4 = coefWords[2][15:0];
    assign coeffs.c5 = coefWords[2][31:16];
    assign coeffs.c6 = coefWords[3][15:0];
    assign coeffs.c7 = coefWords[3][31:16];

    // Decoded address must be clean whenever the bus writes
    addrKnown: assert property (
        @(posedge clk) (cs && (|wrB)) |-> !$isunknown(addr)
    ) else $error("firCoeffRegs: unknown addr during write");

endmodule

// File: verilog/symFir.sv
`timescale 1ns/1ps

module symFir import firPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      clkEn,
    input  coeffSet_t coeffs,
    input  sample_t   sampleIn,
    output acc_t      accOut
);

    localparam int NumTaps = 2 * NumCoeffs - 1;
    localparam int PreW    = $bits(sample_t) + 1;
    localparam int ProdW   = PreW + $bits(coeff_t);

    sample_t                taps    [NumTaps];    // taps[k] holds x[n-k]
    logic signed [PreW-1:0] preSum  [NumCoeffs];
    logic signed [ProdW-1:0] prod   [NumCoeffs];
    coeff_t                 coefArr [NumCoeffs];
    acc_t                   sumNext;

    assign coefArr = '{coeffs.c0, coeffs.c1, coeffs.c2, coeffs.c3,
                       coeffs.c4, coeffs.c5, coeffs.c6, coeffs.c7};

    // ----------------------------------------
    // Stage 1: delay line
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            taps <= '{default: '0};
        end else if (clkEn) begin
            taps[0] <= sampleIn;
            for (int k = 1; k < NumTaps; k++) begin
                taps[k] <= taps[k-1];
            end
        end
    end

    // Fold the symmetric pairs
    always_comb begin
        for (int k = 0; k < NumCoeffs - 1; k++) begin
            preSum[k] = taps[k] + taps[NumTaps-1-k];
        end
        preSum[NumCoeffs-1] = taps[NumCoeffs-1];   // Centre tap stands alone
    end

    // ----------------------------------------
    // Stage 2: multiplies
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            prod <= '{default: '0};
        end else if (clkEn) begin
            for (int k = 0; k < NumCoeffs; k++) begin
                prod[k] <= preSum[k] * coefArr[k];
            end
        end
    end

    // ----------------------------------------
    // Stage 3: adder
    // ----------------------------------------
    always_comb begin
        sumNext = '0;
        for (int k = 0; k < NumCoeffs; k++) begin
            sumNext = sumNext + prod[k];   // Sign-extended to acc_t
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            accOut <= '0;
        end else if (clkEn) begin
            accOut <= sumNext;
        end
    end

    // Pipeline must freeze while the enable is low
    accHold: assert property (
        @(posedge clk) (rstN && !clkEn) |=> $stable(accOut)
    ) else $error("symFir: accOut moved with clkEn low");

endmodule

// File: verilog/firRoundSat.sv
`timescale 1ns/1ps

module firRoundSat import firPkg::*; #(
    parameter int fracBits = 15
) (
    input  logic      clk,
    input  logic      rstN,
    input  logic      clkEn,
    input  iqAcc_t    accIn,
    output iqSample_t sampleOut,
    output iqFlag_t   sat
);

    localparam int SampW = $bits(sample_t);
    localparam int RndW  = $bits(acc_t) + 1;   // Room for the half-LSB add

    localparam sample_t                MaxSample = 18'sh1FFFF;
    localparam sample_t                MinSample = 18'sh20000;
    localparam logic signed [RndW-1:0] HalfLsb   = RndW'(1) << (fracBits - 1);

    iqSample_t sampleNext;
    iqFlag_t   satNext;

    // Returns {clamped, sample}
    function automatic logic [SampW:0] roundSat(acc_t a);
        logic signed [RndW-1:0] rnd;
        logic signed [RndW-1:0] shr;
        rnd = a + HalfLsb;          // Round half up
        shr = rnd >>> fracBits;
        if (shr > MaxSample) begin
            return {1'b1, MaxSample};
        end else if (shr < MinSample) begin
            return {1'b1, MinSample};
        end
        return {1'b0, sample_t'(shr)};
    endfunction

    assign {satNext.i, sampleNext.i} = roundSat(accIn.i);
    assign {satNext.q, sampleNext.q} = roundSat(accIn.q);

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sampleOut <= '0;
            sat       <= '0;
        end else if (clkEn) begin
            sampleOut <= sampleNext;
            sat       <= satNext;   // One enabled cycle per clamp
        end
    end

    satLimitI: assert property (
        @(posedge clk) sat.i |-> (sampleOut.i == MaxSample || sampleOut.i == MinSample)
    ) else $error("firRoundSat: satI without a clamped I output");
    satLimitQ: assert property (
        @(posedge clk) sat.q |-> (sampleOut.q == MaxSample || sampleOut.q == MinSample)
    ) else $error("firRoundSat: satQ without a clamped Q output");

endmodule

// File: verilog/dualFir.sv
`timescale 1ns/1ps

module dualFir import firPkg::*; #(
    parameter logic [9:0] regBase  = 10'h010,   // Eight-word window base
    parameter int         fracBits = 15
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        clkEn,
    input  logic        wr0,
    input  logic        wr1,
    input  logic        wr2,
    input  logic        wr3,
    input  logic [12:0] addr,
    input  logic [31:0] din,
    output logic [31:0] dout,
    input  iqSample_t   iqIn,
    output iqSample_t   iqOut
);

    logic      cs;
    coeffSet_t coeffs;
    iqFlag_t   sat;
    iqAcc_t    iqAcc;
    sample_t   chanIn  [NumChans];
    acc_t      chanAcc [NumChans];

    assign cs = (addr[12:3] == regBase);   // Window decode

    firCoeffRegs uRegs (
        .clk    (clk),
        .rstN   (rstN),
        .cs     (cs),
        .addr   (addr[2:0]),
        .din    (din),
        .wr0    (wr0),
        .wr1    (wr1),
        .wr2    (wr2),
        .wr3    (wr3),
        .dout   (dout),
        .sat    (sat),
        .coeffs (coeffs)
    );

    // ----------------------------------------
    // Channel filters with index 0 for I
    // ----------------------------------------
    assign chanIn[0] = iqIn.i;
    assign chanIn[1] = iqIn.q;

    for (genvar ch = 0; ch < NumChans; ch++) begin : gChan
        symFir uFir (
            .clk      (clk),
            .rstN     (rstN),
            .clkEn    (clkEn),
            .coeffs   (coeffs),
            .sampleIn (chanIn[ch]),
            .accOut   (chanAcc[ch])
        );
    end

    assign iqAcc.i = chanAcc[0];
    assign iqAcc.q = chanAcc[1];

    firRoundSat #(.fracBits(fracBits)) uOut (
        .clk       (clk),
        .rstN      (rstN),
        .clkEn     (clkEn),
        .accIn     (iqAcc),
        .sampleOut (iqOut),
        .sat       (sat)
    );

endmodule

// File: bench/dualFirTb.sv
`timescale 1ns/1ps

module dualFirTb import firPkg::*; ();

    logic        clk;
    logic        rstN;
    logic        clkEn;
    logic        wr0, wr1, wr2, wr3;
    logic [12:0] addr;
    logic [31:0] din;
    logic [31:0] dout;
    iqSample_t   iqIn;
    iqSample_t   iqOut;

    int        errors     = 0;
    int        errMark    = 0;
    int        testsRun   = 0;
    int        testsFail  = 0;
    int        edgeCnt    = 0;    // Enabled edges seen by the DUT
    int        enIdx      = 0;    // Enabled samples driven so far
    int        cycles     = 0;
    int        cycleLimit = 100000;
    logic      edgeHold   = 1'b0; // Last edge had clkEn low out of reset
    iqSample_t heldOut;

    // Parsed case records
    string       kinds[$];
    string       names[$];
    logic [31:0] fa[$], fb[$], fc[$], fd[$];

    // Pending output checks
    int      expTarget[$];
    sample_t expI[$];
    sample_t expQ[$];

    dualFir #(.regBase(10'h010), .fracBits(15)) dut0 (
        .clk(clk), .rstN(rstN), .clkEn(clkEn),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .iqIn(iqIn), .iqOut(iqOut)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Monitors
    // ----------------------------------------
    always @(posedge clk) begin
        if (rstN && clkEn) edgeCnt <= edgeCnt + 1;
        edgeHold <= rstN && !clkEn;
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (edgeHold) begin
            checkVal("iqOut.i hold", iqOut.i, heldOut.i);
            checkVal("iqOut.q hold", iqOut.q, heldOut.q);
        end
        heldOut = iqOut;
        while (expTarget.size() > 0 && expTarget[0] == edgeCnt) begin
            checkVal("iqOut.i", iqOut.i, expI.pop_front());
            checkVal("iqOut.q", iqOut.q, expQ.pop_front());
            void'(expTarget.pop_front());
        end
    end

    // ----------------------------------------
    // Drivers
    // ----------------------------------------
    task automatic idleGap();
        int n;
        n = $urandom % 2;
        repeat (n) begin
            @(posedge clk);
            {wr3, wr2, wr1, wr0} <= 4'b0;
            clkEn <= 1'b0;
        end
    endtask

    task automatic busWrite(input logic [31:0] a, input logic [31:0] d, input logic [31:0] s);
        @(posedge clk);
        clkEn <= 1'b0;
        addr  <= a[12:0];
        din   <= d;
        {wr3, wr2, wr1, wr0} <= s[3:0];
        idleGap();
    endtask

    task automatic busRead(input logic [31:0] a, input logic [31:0] exp);
        @(posedge clk);
        clkEn <= 1'b0;
        addr  <= a[12:0];
        {wr3, wr2, wr1, wr0} <= 4'b0;
        @(negedge clk);
        checkVal("dout", dout, exp);
        idleGap();
    endtask

    task automatic driveSample(input logic en, input logic [31:0] i, input logic [31:0] q);
        @(posedge clk);
        {wr3, wr2, wr1, wr0} <= 4'b0;
        clkEn <= en;
        iqIn  <= {i[17:0], q[17:0]};
        if (en) enIdx++;
    endtask

    task automatic applyReset();
        @(posedge clk);
        rstN  <= 1'b0;
        clkEn <= 1'b0;
        {wr3, wr2, wr1, wr0} <= 4'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        // Output register cleared by the reset
        checkVal("iqOut.i reset", iqOut.i, 32'd0);
        checkVal("iqOut.q reset", iqOut.q, 32'd0);
    endtask

    task automatic endTest(input string name);
        @(posedge clk);
        clkEn <= 1'b0;
        {wr3, wr2, wr1, wr0} <= 4'b0;
        repeat (2) @(negedge clk);
        if (expTarget.size() > 0) begin
            $display("Test %s: %0d expected outputs never appeared", name, expTarget.size());
            errors++;
            expTarget.delete();
            expI.delete();
            expQ.delete();
        end
        testsRun++;
        if (errors != errMark) testsFail++;
        $display("Test %s %s (%0d errors)", name, (errors == errMark) ? "ok" : "failed",
                 errors - errMark);
        errMark = errors;
    endtask

    // ----------------------------------------
    // Case file
    // ----------------------------------------
    task automatic loadCases(input int fh);
        string       tok;
        string       line;
        string       nm;
        logic [31:0] a, b, c, d;
        int          code;
        int          weight;
        weight = 0;
        while (!$feof(fh)) begin
            code = $fscanf(fh, "%s", tok);
            if (code == 1) begin
                a = 0;
                b = 0;
                c = 0;
                d = 0;
                nm = "";
                case (tok)
                    "#": code = $fgets(line, fh);   // Comment to end of line
                    "W": code = $fscanf(fh, "%h %h %h", a, b, c);
                    "R": code = $fscanf(fh, "%h %h", a, b);
                    "S": code = $fscanf(fh, "%d %h %h", a, b, c);
                    "C": code = $fscanf(fh, "%h %h %h %h", a, b, c, d);
                    "F": code = $fscanf(fh, "%d", a);
                    "T": code = $fscanf(fh, "%s", nm);
                    "Z": ;
                    default: begin
                        $display("Unknown record kind %s in the case file", tok);
                        errors++;
                    end
                endcase
                if (tok != "#") begin
                    kinds.push_back(tok);
                    names.push_back(nm);
                    fa.push_back(a);
                    fb.push_back(b);
                    fc.push_back(c);
                    fd.push_back(d);
                    weight += (tok == "F") ? a : 1;   // A flush is one record per sample
                end
            end
        end
        $fclose(fh);
        cycleLimit = 2 * weight + 50;
    endtask

    task automatic runCases();
        for (int r = 0; r < kinds.size(); r++) begin
            case (kinds[r])
                "W": busWrite(fa[r], fb[r], fc[r]);
                "R": busRead(fa[r], fb[r]);
                "S": driveSample(fa[r][0], fb[r], fc[r]);
                "C": begin
                    driveSample(1'b1, fa[r], fb[r]);
                    expTarget.push_back(enIdx + 3);   // Output after the fourth enabled edge
                    expI.push_back(fc[r][17:0]);
                    expQ.push_back(fd[r][17:0]);
                end
                "F": repeat (fa[r]) driveSample(1'b1, 0, 0);
                "Z": applyReset();
                "T": endTest(names[r]);
                default: ;
            endcase
        end
    endtask

    initial begin
        int fh;
        rstN  = 1'b0;
        clkEn = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0;
        addr  = '0;
        din   = '0;
        iqIn  = '0;
        void'($urandom(88627));
        fh = $fopen("bench/dualFirCases.txt", "r");
        if (fh == 0) begin
            $display("Could not open bench/dualFirCases.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            loadCases(fh);
            repeat (2) @(posedge clk);
            rstN <= 1'b1;
            runCases();
            @(posedge clk);
            {wr3, wr2, wr1, wr0} <= 4'b0;
            $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFail, errors);
            if (errors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

// File: bench/dualFirCases.txt
# Records: W addr data strobes, R addr expected, S clkEn i q, C i q expI expQ
# F n zero samples, Z reset, T test name; clkEn and n decimal, all else hex
W 080 FFE00010 F
W 081 AABBCCDD 5
R 081 00BB00DD
W 081 08000100 F
W 082 20001000 F
W 083 40003000 F
W 180 FFFFFFFF F
R 080 FFE00010
R 082 20001000
R 083 40003000
R 084 00000000
R 085 00000000
R 087 00000000
R 188 00000000
T regs
C 20000 0 3FFC0 0   C 0 0 00080 0   C 0 0 3FC00 0
C 0 0 3E000 0   C 0 0 3C000 0   C 0 0 38000 0
C 0 0 34000 0   C 0 0 30000 0   C 0 0 34000 0
C 0 0 38000 0   C 0 0 3C000 0   C 0 0 3E000 0
C 0 0 3FC00 0   C 0 0 00080 0   C 0 0 3FFC0 0
F 3
T impulse
C 01000 00400 00002 00001
C 3F000 3FC00 3FFFA 3FFFF
C 0 0 00024 00009
F 3
T channels
F 12
C 01000 00400 00002 00001
S 0 1FFFF 20000   S 0 1FFFF 20000
C 3F000 3FC00 3FFFA 3FFFF
S 0 12345 0ABCD
C 0 0 00024 00009
F 3
T clken
W 080 7FFF7FFF F   W 081 7FFF7FFF F   W 082 7FFF7FFF F   W 083 7FFF7FFF F
S 1 1FFFF 20000   S 1 1FFFF 20000   S 1 1FFFF 20000   S 1 1FFFF 20000   S 1 1FFFF 20000
S 1 1FFFF 20000   S 1 1FFFF 20000   S 1 1FFFF 20000   S 1 1FFFF 20000   S 1 1FFFF 20000
S 1 1FFFF 20000   S 1 1FFFF 20000   S 1 1FFFF 20000   S 1 1FFFF 20000
C 1FFFF 20000 1FFFF 20000
F 18
R 084 00000003
W 084 00000003 1
R 084 00000000
T saturate
S 1 1FFFF 1FFFF   S 1 1FFFF 1FFFF   S 1 1FFFF 1FFFF   S 1 1FFFF 1FFFF
S 1 1FFFF 1FFFF   S 1 1FFFF 1FFFF   S 1 1FFFF 1FFFF   S 1 1FFFF 1FFFF
R 084 00000003
Z
R 080 00000000   R 083 00000000   R 084 00000000
C 00100 00100 0 0
F 3
T reset

// File: dualFir.f
verilog/firPkg.sv
verilog/firCoeffRegs.sv
verilog/symFir.sv
verilog/firRoundSat.sv
verilog/dualFir.sv
bench/dualFirTb.sv

// File: Bender.yml
package:
  name: dualFir

sources:
  - verilog/firPkg.sv
  - verilog/firCoeffRegs.sv
  - verilog/symFir.sv
  - verilog/firRoundSat.sv
  - verilog/dualFir.sv
  - target: test
    files:
      - bench/dualFirTb.sv
